// File: include/dmac_defines.svh
// Shared DMA widths, depths, core count and register offsets; include where needed
`ifndef DMAC_DEFINES_SVH
`define DMAC_DEFINES_SVH

`define DMAC_NB_CORES        4
`define DMAC_ADDR_W          32
`define DMAC_DATA_W          32
`define DMAC_REG_ADDR_W      10
`define DMAC_ID_W            28
`define DMAC_QUEUE_DEPTH     16
`define DMAC_BUF_DEPTH       4

// Byte offsets inside one core's register bank
`define DMAC_REG_SRC         10'h000
`define DMAC_REG_DST         10'h004
`define DMAC_REG_LEN         10'h008
`define DMAC_REG_SRC_STRIDE  10'h00C
`define DMAC_REG_DST_STRIDE  10'h010
`define DMAC_REG_REPS        10'h014
`define DMAC_REG_NEXT_ID     10'h018
`define DMAC_REG_DONE_ID     10'h01C
`define DMAC_REG_STATUS      10'h020

`endif

// File: verilog/dmac_pkg.sv
// DMA data, address, id and transfer request types, imported by the RTL modules
`default_nettype none
`include "dmac_defines.svh"

package dmac_pkg;

  typedef logic [`DMAC_DATA_W-1:0] word_t;
  typedef logic [`DMAC_ADDR_W-1:0] addr_t;
  typedef logic [`DMAC_ID_W-1:0]   id_t;

  // One row, len in bytes
  typedef struct packed {
    addr_t src;
    addr_t dst;
    addr_t len;
  } xfer_1d_t;

  // Full 2D request as programmed by a core
  typedef struct packed {
    xfer_1d_t row;
    addr_t    src_stride;
    addr_t    dst_stride;
    addr_t    reps;
  } xfer_2d_t;

endpackage

`default_nettype wire

// File: verilog/dmac_req_fifo.sv
// Synchronous circular-buffer FIFO with a type parameter payload, used as queue and buffer
`default_nettype none

module dmac_req_fifo #(
  parameter int unsigned DEPTH  = 4,
  parameter type         data_t = logic
) (
  input  wire logic  clk_i,
  input  wire logic  reset_i,
  input  wire logic  push_i,
  input  wire data_t data_i,
  output logic       full_o,
  input  wire logic  pop_i,
  output data_t      data_o,
  output logic       empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  data_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_pop  = pop_i && !empty_o;
  // Full FIFO still accepts a push when it pops in the same cycle
  assign do_push = push_i && (!full_o || do_pop);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dmac_reg_frontend.sv
// Per-core DMA register banks; fixed-priority grant, launch ids and completion counter
`default_nettype none
`include "dmac_defines.svh"

module dmac_reg_frontend (
  input  wire logic                                            clk_i,
  input  wire logic                                            reset_i,
  input  wire logic [`DMAC_NB_CORES-1:0]                       ctrl_req_i,
  input  wire logic [`DMAC_NB_CORES-1:0][`DMAC_REG_ADDR_W-1:0] ctrl_add_i,
  input  wire logic [`DMAC_NB_CORES-1:0]                       ctrl_wen_i,
  input  wire dmac_pkg::word_t [`DMAC_NB_CORES-1:0]            ctrl_wdata_i,
  output logic [`DMAC_NB_CORES-1:0]                            ctrl_gnt_o,
  output logic [`DMAC_NB_CORES-1:0]                            ctrl_r_valid_o,
  output dmac_pkg::word_t [`DMAC_NB_CORES-1:0]                 ctrl_r_rdata_o,
  input  wire logic                                            queue_full_i,
  output logic                                                 queue_push_o,
  output dmac_pkg::xfer_2d_t                                   queue_data_o,
  input  wire logic                                            xfer_done_i,
  input  wire logic                                            busy_i,
  output logic                                                 term_event_o
);

  import dmac_pkg::*;

  localparam int unsigned NB    = `DMAC_NB_CORES;
  localparam int unsigned SEL_W = (NB > 1) ? $clog2(NB) : 1;

  xfer_2d_t          bank_q [NB];
  id_t               next_id_q;
  id_t               done_q;
  id_t               launch_id;
  logic [NB-1:0]     is_launch;
  logic [NB-1:0]     eligible;
  logic [SEL_W-1:0]  sel;
  word_t             rdata;

  // ----------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------

  // ctrl_wen_i is high for a write
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      is_launch[i] = ctrl_req_i[i] && !ctrl_wen_i[i]
                     && (ctrl_add_i[i] == `DMAC_REG_NEXT_ID);
    end
  end

  // Launches wait while the queue is full
  assign eligible   = ctrl_req_i & ~(is_launch & {NB{queue_full_i}});
  assign ctrl_gnt_o = eligible & (~eligible + 1'b1);

  always_comb begin
    sel = '0;
    for (int i = NB - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        sel = SEL_W'(i);
      end
    end
  end

  assign queue_push_o = |(ctrl_gnt_o & is_launch);
  assign queue_data_o = bank_q[sel];
  assign launch_id    = next_id_q + 1'b1;

  // ----------------------------------------------------------
  // Register access
  // ----------------------------------------------------------

  always_comb begin
    rdata = '0;
    if (!ctrl_wen_i[sel]) begin
      case (ctrl_add_i[sel])
        `DMAC_REG_SRC:        rdata = bank_q[sel].row.src;
        `DMAC_REG_DST:        rdata = bank_q[sel].row.dst;
        `DMAC_REG_LEN:        rdata = bank_q[sel].row.len;
        `DMAC_REG_SRC_STRIDE: rdata = bank_q[sel].src_stride;
        `DMAC_REG_DST_STRIDE: rdata = bank_q[sel].dst_stride;
        `DMAC_REG_REPS:       rdata = bank_q[sel].reps;
        `DMAC_REG_NEXT_ID:    rdata = word_t'(launch_id);
        `DMAC_REG_DONE_ID:    rdata = word_t'(done_q);
        `DMAC_REG_STATUS:     rdata = word_t'(busy_i);
        default:              rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (|ctrl_gnt_o) begin
      ctrl_r_rdata_o[sel] <= rdata;
      if (ctrl_wen_i[sel]) begin
        case (ctrl_add_i[sel])
          `DMAC_REG_SRC:        bank_q[sel].row.src    <= ctrl_wdata_i[sel];
          `DMAC_REG_DST:        bank_q[sel].row.dst    <= ctrl_wdata_i[sel];
          `DMAC_REG_LEN:        bank_q[sel].row.len    <= ctrl_wdata_i[sel];
          `DMAC_REG_SRC_STRIDE: bank_q[sel].src_stride <= ctrl_wdata_i[sel];
          `DMAC_REG_DST_STRIDE: bank_q[sel].dst_stride <= ctrl_wdata_i[sel];
          `DMAC_REG_REPS:       bank_q[sel].reps       <= ctrl_wdata_i[sel];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_r_valid_o <= '0;
      term_event_o   <= 1'b0;
      next_id_q      <= '0;
      done_q         <= '0;
    end else begin
      ctrl_r_valid_o <= ctrl_gnt_o;
      term_event_o   <= xfer_done_i;
      if (queue_push_o) begin
        next_id_q <= launch_id;
      end
      if (xfer_done_i) begin
        done_q <= done_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dmac_2d_midend.sv
// 2D midend that splits one queued request into strided rows and counts their completion
`default_nettype none

module dmac_2d_midend (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               req_valid_i,
  input  wire dmac_pkg::xfer_2d_t req_i,
  output logic                    req_pop_o,
  output logic                    row_valid_o,
  output dmac_pkg::xfer_1d_t      row_o,
  input  wire logic               row_take_i,
  input  wire logic               row_done_i,
  output logic                    xfer_done_o,
  output logic                    busy_o
);

  import dmac_pkg::*;

  xfer_2d_t cur_q;
  addr_t    rows_q;
  addr_t    taken_q;
  addr_t    done_rows_q;
  logic     active_q;
  logic     last_row;

  assign req_pop_o   = req_valid_i && !active_q;
  assign row_valid_o = active_q && (taken_q != rows_q);
  assign row_o       = cur_q.row;
  assign last_row    = (done_rows_q + 1'b1 == rows_q);
  assign xfer_done_o = active_q && row_done_i && last_row;
  assign busy_o      = active_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q    <= 1'b0;
      taken_q     <= '0;
      done_rows_q <= '0;
    end else if (req_pop_o) begin
      active_q    <= 1'b1;
      taken_q     <= '0;
      done_rows_q <= '0;
    end else if (active_q) begin
      if (row_take_i) begin
        taken_q <= taken_q + 1'b1;
      end
      if (xfer_done_o) begin
        active_q <= 1'b0;
      end else if (row_done_i) begin
        done_rows_q <= done_rows_q + 1'b1;
      end
    end
  end

  // Zero reps still moves one row
  always_ff @(posedge clk_i) begin
    if (req_pop_o) begin
      cur_q  <= req_i;
      rows_q <= (req_i.reps == '0) ? addr_t'(1) : req_i.reps;
    end else if (row_take_i) begin
      cur_q.row.src <= cur_q.row.src + cur_q.src_stride;
      cur_q.row.dst <= cur_q.row.dst + cur_q.dst_stride;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dmac_copy_backend.sv
// Row copy backend moving one word at a time from the read port through a buffer to the write port
`default_nettype none
`include "dmac_defines.svh"

module dmac_copy_backend (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               row_valid_i,
  input  wire dmac_pkg::xfer_1d_t row_i,
  output logic                    row_take_o,
  output logic                    row_done_o,
  output logic                    busy_o,
  output logic                    rd_req_o,
  output dmac_pkg::addr_t         rd_addr_o,
  input  wire logic               rd_gnt_i,
  input  wire logic               rd_rvalid_i,
  input  wire dmac_pkg::word_t    rd_rdata_i,
  output logic                    wr_req_o,
  output dmac_pkg::addr_t         wr_addr_o,
  output dmac_pkg::word_t         wr_wdata_o,
  input  wire logic               wr_gnt_i
);

  import dmac_pkg::*;

  localparam int unsigned DEPTH      = `DMAC_BUF_DEPTH;
  localparam int unsigned CNT_W      = $clog2(DEPTH + 1);
  localparam addr_t       WORD_BYTES = addr_t'(`DMAC_DATA_W / 8);

  addr_t            rd_addr_q;
  addr_t            wr_addr_q;
  addr_t            rd_left_q;
  addr_t            wr_left_q;
  logic [CNT_W-1:0] in_use_q;
  logic             busy_q;
  logic             rd_fire;
  logic             wr_fire;
  logic             buf_empty;

  assign row_take_o = row_valid_i && !busy_q;
  assign busy_o     = busy_q;

  // Slots in use count reads in flight plus buffered words
  assign rd_req_o  = busy_q && (rd_left_q != '0) && (in_use_q < CNT_W'(DEPTH));
  assign rd_addr_o = rd_addr_q;
  assign rd_fire   = rd_req_o && rd_gnt_i;

  assign wr_req_o  = !buf_empty;
  assign wr_addr_o = wr_addr_q;
  assign wr_fire   = wr_req_o && wr_gnt_i;

  // Empty rows finish the cycle after they are taken
  assign row_done_o = busy_q && ((wr_left_q == '0)
                      || (wr_fire && (wr_left_q == WORD_BYTES)));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      rd_left_q <= '0;
      wr_left_q <= '0;
      in_use_q  <= '0;
    end else begin
      in_use_q <= in_use_q + CNT_W'(rd_fire) - CNT_W'(wr_fire);
      if (row_take_o) begin
        busy_q    <= 1'b1;
        rd_left_q <= row_i.len;
        wr_left_q <= row_i.len;
      end else begin
        if (row_done_o) begin
          busy_q <= 1'b0;
        end
        if (rd_fire) begin
          rd_left_q <= rd_left_q - WORD_BYTES;
        end
        if (wr_fire) begin
          wr_left_q <= wr_left_q - WORD_BYTES;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (row_take_o) begin
      rd_addr_q <= row_i.src;
      wr_addr_q <= row_i.dst;
    end else begin
      if (rd_fire) begin
        rd_addr_q <= rd_addr_q + WORD_BYTES;
      end
      if (wr_fire) begin
        wr_addr_q <= wr_addr_q + WORD_BYTES;
      end
    end
  end

  dmac_req_fifo #(
    .DEPTH  ( DEPTH  ),
    .data_t ( word_t )
  ) i_data_buf (
    .clk_i,
    .reset_i,
    .push_i  ( rd_rvalid_i ),
    .data_i  ( rd_rdata_i  ),
    .full_o  (             ),
    .pop_i   ( wr_fire     ),
    .data_o  ( wr_wdata_o  ),
    .empty_o ( buf_empty   )
  );

endmodule

`default_nettype wire

// File: verilog/dmac_top.sv
// DMA top level joining the register frontend, request queue, 2D midend and copy backend
`default_nettype none
`include "dmac_defines.svh"

module dmac_top (
  input  wire logic                                            clk_i,
  input  wire logic                                            reset_i,
  input  wire logic [`DMAC_NB_CORES-1:0]                       ctrl_req_i,
  input  wire logic [`DMAC_NB_CORES-1:0][`DMAC_REG_ADDR_W-1:0] ctrl_add_i,
  input  wire logic [`DMAC_NB_CORES-1:0]                       ctrl_wen_i,
  input  wire dmac_pkg::word_t [`DMAC_NB_CORES-1:0]            ctrl_wdata_i,
  output logic [`DMAC_NB_CORES-1:0]                            ctrl_gnt_o,
  output logic [`DMAC_NB_CORES-1:0]                            ctrl_r_valid_o,
  output dmac_pkg::word_t [`DMAC_NB_CORES-1:0]                 ctrl_r_rdata_o,
  output logic                                                 rd_req_o,
  output dmac_pkg::addr_t                                      rd_addr_o,
  input  wire logic                                            rd_gnt_i,
  input  wire logic                                            rd_rvalid_i,
  input  wire dmac_pkg::word_t                                 rd_rdata_i,
  output logic                                                 wr_req_o,
  output dmac_pkg::addr_t                                      wr_addr_o,
  output dmac_pkg::word_t                                      wr_wdata_o,
  input  wire logic                                            wr_gnt_i,
  output logic [`DMAC_NB_CORES-1:0]                            term_event_o,
  output logic                                                 busy_o
);

  import dmac_pkg::*;

  xfer_2d_t queue_in;
  xfer_2d_t queue_head;
  xfer_1d_t row;
  logic     queue_push;
  logic     queue_full;
  logic     queue_pop;
  logic     queue_empty;
  logic     row_valid;
  logic     row_take;
  logic     row_done;
  logic     xfer_done;
  logic     mid_busy;
  logic     be_busy;
  logic     term_event;

  // Completion broadcast to every core
  assign term_event_o = {`DMAC_NB_CORES{term_event}};
  assign busy_o       = !queue_empty || mid_busy || be_busy || term_event;

  // ----------------------------------------------------------
  // Frontend and request queue
  // ----------------------------------------------------------

  dmac_reg_frontend i_frontend (
    .clk_i,
    .reset_i,
    .ctrl_req_i,
    .ctrl_add_i,
    .ctrl_wen_i,
    .ctrl_wdata_i,
    .ctrl_gnt_o,
    .ctrl_r_valid_o,
    .ctrl_r_rdata_o,
    .queue_full_i ( queue_full ),
    .queue_push_o ( queue_push ),
    .queue_data_o ( queue_in   ),
    .xfer_done_i  ( xfer_done  ),
    .busy_i       ( busy_o     ),
    .term_event_o ( term_event )
  );

  dmac_req_fifo #(
    .DEPTH  ( `DMAC_QUEUE_DEPTH ),
    .data_t ( xfer_2d_t         )
  ) i_req_queue (
    .clk_i,
    .reset_i,
    .push_i  ( queue_push  ),
    .data_i  ( queue_in    ),
    .full_o  ( queue_full  ),
    .pop_i   ( queue_pop   ),
    .data_o  ( queue_head  ),
    .empty_o ( queue_empty )
  );

  // ----------------------------------------------------------
  // Midend and backend
  // ----------------------------------------------------------

  dmac_2d_midend i_midend (
    .clk_i,
    .reset_i,
    .req_valid_i ( !queue_empty ),
    .req_i       ( queue_head   ),
    .req_pop_o   ( queue_pop    ),
    .row_valid_o ( row_valid    ),
    .row_o       ( row          ),
    .row_take_i  ( row_take     ),
    .row_done_i  ( row_done     ),
    .xfer_done_o ( xfer_done    ),
    .busy_o      ( mid_busy     )
  );

  dmac_copy_backend i_backend (
    .clk_i,
    .reset_i,
    .row_valid_i ( row_valid ),
    .row_i       ( row       ),
    .row_take_o  ( row_take  ),
    .row_done_o  ( row_done  ),
    .busy_o      ( be_busy   ),
    .rd_req_o,
    .rd_addr_o,
    .rd_gnt_i,
    .rd_rvalid_i,
    .rd_rdata_i,
    .wr_req_o,
    .wr_addr_o,
    .wr_wdata_o,
    .wr_gnt_i
  );

endmodule

`default_nettype wire

// File: tb/dmac_sva.sv
// Concurrent checks on the DMA top level, attached to dmac_top by bind from the testbench
`default_nettype none
`include "dmac_defines.svh"

module dmac_sva (
  input wire logic                      clk_i,
  input wire logic                      reset_i,
  input wire logic [`DMAC_NB_CORES-1:0] ctrl_gnt_o,
  input wire logic [`DMAC_NB_CORES-1:0] ctrl_r_valid_o,
  input wire logic                      rd_req_o,
  input wire logic                      wr_req_o,
  input wire logic                      wr_gnt_i,
  input wire logic [`DMAC_ADDR_W-1:0]   wr_addr_o,
  input wire logic [`DMAC_DATA_W-1:0]   wr_wdata_o,
  input wire logic [`DMAC_NB_CORES-1:0] term_event_o,
  input wire logic                      busy_o
);

  localparam logic [31:0] KEY        = 32'hC0DE0000;
  localparam logic [31:0] DST_OFFSET = 32'h0001_0000;

  int unsigned                 fail_count = 0;
  logic [`DMAC_NB_CORES-1:0]   gnt_q;

  always_ff @(posedge clk_i) begin
    gnt_q <= ctrl_gnt_o;
  end

  // Each write carries the key XOR its source address
  data_ok: assert property (@(posedge clk_i) disable iff (reset_i)
    (wr_req_o && wr_gnt_i) |-> (wr_wdata_o == (KEY ^ (wr_addr_o - DST_OFFSET))))
  else begin
    fail_count++;
    $error("ERR wr_wdata_o got %h expected %h", $sampled(wr_wdata_o),
           KEY ^ ($sampled(wr_addr_o) - DST_OFFSET));
  end

  // Quiet outputs through reset and the cycle after
  reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> (ctrl_gnt_o == '0 && ctrl_r_valid_o == '0 && !rd_req_o && !wr_req_o
                 && term_event_o == '0 && !busy_o))
  else begin
    fail_count++;
    $error("An output was active during reset or in the cycle after it");
  end

  one_grant: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(ctrl_gnt_o))
  else begin
    fail_count++;
    $error("ERR ctrl_gnt_o got %h expected at most one bit set", $sampled(ctrl_gnt_o));
  end

  // Read data valid exactly one cycle after the grant
  rvalid_follows: assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_r_valid_o == gnt_q)
  else begin
    fail_count++;
    $error("ERR ctrl_r_valid_o got %h expected %h", $sampled(ctrl_r_valid_o),
           $sampled(gnt_q));
  end

  event_all: assert property (@(posedge clk_i) disable iff (reset_i)
    (term_event_o != '0) |-> (term_event_o == '1))
  else begin
    fail_count++;
    $error("ERR term_event_o got %h expected %h", $sampled(term_event_o), {`DMAC_NB_CORES{1'b1}});
  end

  event_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    term_event_o[0] |=> !term_event_o[0])
  else begin
    fail_count++;
    $error("Completion event stayed high for more than one cycle");
  end

endmodule

`default_nettype wire

// File: tb/dmac_tb.sv
// Testbench for the DMA top level; programs the cores, models memory and watches for hangs
`default_nettype none
`include "dmac_defines.svh"

module dmac_tb;

  localparam int          NB         = `DMAC_NB_CORES;
  localparam logic [31:0] KEY        = 32'hC0DE0000;
  localparam logic [31:0] DST_OFFSET = 32'h0001_0000;
  localparam int          NUM_XFERS  = 25;

  logic                               clk_i;
  logic                               reset_i;
  logic [NB-1:0]                      ctrl_req_i;
  logic [NB-1:0][`DMAC_REG_ADDR_W-1:0] ctrl_add_i;
  logic [NB-1:0]                      ctrl_wen_i;
  logic [NB-1:0][31:0]                ctrl_wdata_i;
  logic [NB-1:0]                      ctrl_gnt_o;
  logic [NB-1:0]                      ctrl_r_valid_o;
  logic [NB-1:0][31:0]                ctrl_r_rdata_o;
  logic                               rd_req_o;
  logic [31:0]                        rd_addr_o;
  logic                               rd_gnt_i    = 1'b0;
  logic                               rd_rvalid_i = 1'b0;
  logic [31:0]                        rd_rdata_i  = '0;
  logic                               wr_req_o;
  logic [31:0]                        wr_addr_o;
  logic [31:0]                        wr_wdata_o;
  logic                               wr_gnt_i    = 1'b0;
  logic [NB-1:0]                      term_event_o;
  logic                               busy_o;

  integer      seed     = 32'h8aa7;
  logic        rand_gnt = 1'b0;
  logic [31:0] rnd;
  logic [31:0] gnt_rnd;
  logic [31:0] exp_id;
  int          cyc      = 0;
  int          events   = 0;
  int          writes   = 0;
  int          mem_reqs = 0;
  logic [31:0] pend_addr [$];
  int          pend_ready [$];
  logic        win_on = 1'b0;
  logic [31:0] win_base;
  logic [31:0] win_stride;
  logic [31:0] win_len;
  logic [31:0] win_rows;

  dmac_top dut0 (.*);

  bind dmac_top dmac_sva sva0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (NUM_XFERS * 2000) @(posedge clk_i);
    $display("Timeout: the transfers did not complete in time");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic abort_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("ERR %s got %h expected %h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic abort_with(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else abort_value(name, got, exp);
  endtask

  function automatic logic in_window(input logic [31:0] addr);
    logic        hit;
    logic [31:0] lo;
    hit = 1'b0;
    for (int r = 0; r < int'(win_rows); r++) begin
      lo = win_base + 32'(r) * win_stride;
      if (addr >= lo && addr < lo + win_len) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // One-hot of the lowest core index set in mask
  function automatic logic [NB-1:0] lowest_core(input logic [NB-1:0] mask);
    logic [NB-1:0] pick;
    logic          found;
    pick  = '0;
    found = 1'b0;
    for (int i = 0; i < NB; i++) begin
      if (mask[i] && !found) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
    return pick;
  endfunction

  // ----------------------------------------------------------
  // Memory model and monitors
  // ----------------------------------------------------------

  always @(posedge clk_i) begin
    cyc++;
    if (rd_req_o && rd_gnt_i) begin
      rnd = $random(seed);
      pend_addr.push_back(rd_addr_o);
      pend_ready.push_back(cyc + int'(rnd[1:0] % 2'd3));
    end
    if (rd_req_o || wr_req_o) begin
      mem_reqs++;
    end
    if (wr_req_o && wr_gnt_i) begin
      writes++;
      if (win_on) begin
        assert (in_window(wr_addr_o)) else abort_value("wr_addr_o", wr_addr_o, win_base);
      end
    end
    if (term_event_o[0]) begin
      events++;
    end
  end

  // Read data comes back in order, 1 to 3 cycles after the grant
  always @(negedge clk_i) begin
    gnt_rnd     = $random(seed);
    rd_gnt_i    = !rand_gnt || gnt_rnd[0];
    wr_gnt_i    = !rand_gnt || (gnt_rnd[2:1] == 2'b00);
    rd_rvalid_i = 1'b0;
    if (pend_ready.size() > 0 && pend_ready[0] <= cyc) begin
      rd_rvalid_i = 1'b1;
      rd_rdata_i  = pend_addr.pop_front() ^ KEY;
      void'(pend_ready.pop_front());
    end
    if (dut0.sva0.fail_count != 0) begin
      abort_with("A bound assertion failed");
    end
  end

  // ----------------------------------------------------------
  // Control port access
  // ----------------------------------------------------------

  task automatic reg_access(input int core, input logic wen, input logic [9:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    ctrl_req_i[core]   = 1'b1;
    ctrl_wen_i[core]   = wen;
    ctrl_add_i[core]   = addr;
    ctrl_wdata_i[core] = wdata;
    do begin
      @(posedge clk_i);
    end while (!ctrl_gnt_o[core]);
    @(negedge clk_i);
    ctrl_req_i[core] = 1'b0;
    assert (ctrl_r_valid_o[core]) else abort_with("Control read data never became valid");
    rdata = ctrl_r_rdata_o[core];
  endtask

  task automatic program_xfer(input int core, input logic [31:0] src, input logic [31:0] len,
                              input logic [31:0] stride, input logic [31:0] reps);
    logic [31:0] unused;
    reg_access(core, 1'b1, `DMAC_REG_SRC, src, unused);
    reg_access(core, 1'b1, `DMAC_REG_DST, src + DST_OFFSET, unused);
    reg_access(core, 1'b1, `DMAC_REG_LEN, len, unused);
    reg_access(core, 1'b1, `DMAC_REG_SRC_STRIDE, stride, unused);
    reg_access(core, 1'b1, `DMAC_REG_DST_STRIDE, stride, unused);
    reg_access(core, 1'b1, `DMAC_REG_REPS, reps, unused);
  endtask

  // Lowest requesting core wins, ids rise in grant order
  task automatic launch(input logic [NB-1:0] mask);
    logic [NB-1:0] pend;
    logic [NB-1:0] g;
    pend = mask;
    for (int i = 0; i < NB; i++) begin
      if (mask[i]) begin
        ctrl_req_i[i] = 1'b1;
        ctrl_wen_i[i] = 1'b0;
        ctrl_add_i[i] = `DMAC_REG_NEXT_ID;
      end
    end
    while (pend != '0) begin
      @(posedge clk_i);
      g = ctrl_gnt_o & pend;
      @(negedge clk_i);
      if (g != '0) begin
        expect_eq("ctrl_gnt_o", 32'(g), 32'(lowest_core(pend)));
        for (int i = 0; i < NB; i++) begin
          if (g[i]) begin
            ctrl_req_i[i] = 1'b0;
            expect_eq("next_id", ctrl_r_rdata_o[i], exp_id);
            exp_id++;
          end
        end
        pend &= ~g;
      end
    end
  endtask

  task automatic wait_events(input int n);
    while (events < n) begin
      @(negedge clk_i);
    end
  endtask

  task automatic set_window(input logic [31:0] base, input logic [31:0] stride,
                            input logic [31:0] len, input logic [31:0] rows);
    win_base   = base;
    win_stride = stride;
    win_len    = len;
    win_rows   = rows;
    win_on     = 1'b1;
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    logic [31:0] rdata;
    int          base_writes;
    int          base_reqs;
    reset_i      = 1'b1;
    ctrl_req_i   = '0;
    ctrl_wen_i   = '0;
    ctrl_add_i   = '0;
    ctrl_wdata_i = '0;
    exp_id       = 32'd1;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    reg_access(3, 1'b0, `DMAC_REG_DONE_ID, '0, rdata);
    expect_eq("done_id", rdata, 32'd0);

    // 1D copy of 16 words
    set_window(32'h0001_1000, 32'd0, 32'd64, 32'd1);
    program_xfer(0, 32'h1000, 32'd64, 32'd0, 32'd1);
    base_writes = writes;
    launch(4'b0001);
    wait_events(1);
    expect_eq("write count", 32'(writes - base_writes), 32'd16);

    // Three rows of two words, 32 bytes apart
    set_window(32'h0001_2000, 32'd32, 32'd8, 32'd3);
    program_xfer(1, 32'h2000, 32'd8, 32'd32, 32'd3);
    base_writes = writes;
    launch(4'b0010);
    wait_events(2);
    expect_eq("write count", 32'(writes - base_writes), 32'd6);
    win_on = 1'b0;

    // Two cores launch in the same cycle
    program_xfer(2, 32'h3000, 32'd16, 32'd0, 32'd1);
    base_writes = writes;
    launch(4'b0110);
    wait_events(4);
    expect_eq("write count", 32'(writes - base_writes), 32'd10);
    reg_access(3, 1'b0, `DMAC_REG_DONE_ID, '0, rdata);
    expect_eq("done_id", rdata, 32'd4);
    reg_access(3, 1'b0, `DMAC_REG_STATUS, '0, rdata);
    expect_eq("status", rdata, 32'd0);
    expect_eq("busy_o", 32'(busy_o), 32'd0);

    // More launches than the queue holds, under random grants
    rand_gnt = 1'b1;
    program_xfer(0, 32'h4000, 32'd8, 32'd16, 32'd2);
    base_writes = writes;
    repeat (20) launch(4'b0001);
    wait_events(24);
    expect_eq("write count", 32'(writes - base_writes), 32'd80);
    rand_gnt = 1'b0;

    // Empty row touches no memory
    program_xfer(3, 32'h5000, 32'd0, 32'd0, 32'd1);
    base_reqs = mem_reqs;
    launch(4'b1000);
    wait_events(25);
    expect_eq("memory requests", 32'(mem_reqs - base_reqs), 32'd0);
    reg_access(0, 1'b0, `DMAC_REG_DONE_ID, '0, rdata);
    expect_eq("done_id", rdata, 32'd25);
    expect_eq("busy_o", 32'(busy_o), 32'd0);

    if (dut0.sva0.fail_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "bound assertions reported failures");
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
verilog/dmac_pkg.sv
verilog/dmac_req_fifo.sv
verilog/dmac_reg_frontend.sv
verilog/dmac_2d_midend.sv
verilog/dmac_copy_backend.sv
verilog/dmac_top.sv
tb/dmac_sva.sv
tb/dmac_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dmac_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
